//--- flist.f
+incdir+common
common/serial_pkg.sv
uart/uart_rx.sv
uart/uart_rx_buffer.sv
uart/uart_tx.sv
logic/io_regs.sv
logic/serial_io_top.sv
verif/tb_serial_io.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the serial I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_serial_io -f flist.f -o sim_tb \
	|| { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/sim_tb)"
echo "$out"

echo "$out" | grep -q "^Simulation finished: PASS$" && exit 0 || exit 1

//--- verif/tb_serial_io.sv
// Testbench for the serial I/O block with stimulus table, serial driver, tx monitor and checks
`timescale 1ns/10ps
`default_nettype none

`include "serial_config.svh"

module tb_serial_io import serial_pkg::*; ();

	localparam int clks_per_bit = `SERIAL_CLKS_PER_BIT;
	localparam int max_entries = 64;
	// Longest write is ten bit periods plus one divider period
	localparam int bus_watchdog = 11 * clks_per_bit + 50;
	localparam addr_t addr_led = `SERIAL_ADDR_LED;
	localparam addr_t addr_data = `SERIAL_ADDR_DATA;
	localparam addr_t addr_unmapped = 32'h0200_0008;

	localparam logic [2:0] op_write = 3'd0;
	localparam logic [2:0] op_read = 3'd1;
	localparam logic [2:0] op_send = 3'd2;
	localparam logic [2:0] op_expect_tx = 3'd3;
	localparam logic [2:0] op_no_ready = 3'd4;

	logic clk;
	logic resetn;
	logic mem_valid;
	addr_t mem_addr;
	word_t mem_wdata;
	strb_t mem_wstrb;
	logic mem_ready;
	word_t mem_rdata;
	logic rx;
	logic tx;
	led_t leds;
	logic bus_error;

	// Stimulus table
	logic [2:0] t_op [max_entries];
	addr_t t_addr [max_entries];
	strb_t t_strb [max_entries];
	word_t t_data [max_entries];
	word_t t_exp [max_entries];
	int n_entries;

	logic [31:0] rng;
	int errors;
	int cycle = 0;
	int cycle_limit = 1_000_000;
	int ready_cycle;
	int stop_cycle;

	serial_io_top dut (
		.clk(clk),
		.resetn(resetn),
		.mem_valid(mem_valid),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata),
		.rx(rx),
		.tx(tx),
		.leds(leds),
		.bus_error(bus_error)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("Timeout: the run hung and did not end within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic rand_byte(output byte_t b);
		rng = xorshift32(rng);
		b = rng[7:0];
	endtask

	// LED reads back zero-extended, serial bytes likewise
	function automatic word_t led_word(input word_t w);
		return {27'd0, w[4:0]};
	endfunction

	function automatic word_t rx_word(input byte_t b);
		return {24'd0, b};
	endfunction

	task automatic add_entry(input logic [2:0] op, input addr_t addr, input strb_t strb,
			input word_t data, input word_t exp);
		t_op[n_entries] = op;
		t_addr[n_entries] = addr;
		t_strb[n_entries] = strb;
		t_data[n_entries] = data;
		t_exp[n_entries] = exp;
		n_entries = n_entries + 1;
	endtask

	task automatic build_table();
		byte_t b [5];
		byte_t r;
		int i;
		n_entries = 0;
		add_entry(op_write, addr_led, 4'b1111, 32'h0000_0015, led_word(32'h15));
		add_entry(op_read, addr_led, 4'b0000, 32'h0, led_word(32'h15));
		// Strobe bit 0 clear leaves the LEDs alone
		add_entry(op_write, addr_led, 4'b1110, 32'h0000_000a, led_word(32'h15));
		add_entry(op_read, addr_led, 4'b0000, 32'h0, led_word(32'h15));
		add_entry(op_write, addr_led, 4'b0001, 32'hffff_ffea, led_word(32'hffff_ffea));
		add_entry(op_read, addr_led, 4'b0000, 32'h0, led_word(32'hffff_ffea));
		add_entry(op_read, addr_data, 4'b0000, 32'h0, 32'hffff_ffff);
		add_entry(op_expect_tx, addr_data, 4'b0001, 32'h1234_56a5, rx_word(8'ha5));
		rand_byte(r);
		add_entry(op_expect_tx, addr_data, 4'b0001, {24'h5a5a5a, r}, rx_word(r));
		add_entry(op_send, addr_data, 4'b0000, rx_word(8'h3c), 32'h0);
		rand_byte(r);
		add_entry(op_send, addr_data, 4'b0000, rx_word(r), 32'h0);
		add_entry(op_read, addr_data, 4'b0000, 32'h0, rx_word(8'h3c));
		add_entry(op_read, addr_data, 4'b0000, 32'h0, rx_word(r));
		add_entry(op_read, addr_data, 4'b0000, 32'h0, 32'hffff_ffff);
		// Five bytes into a four-byte buffer
		for (i = 0; i < 5; i++) begin
			rand_byte(b[i]);
			add_entry(op_send, addr_data, 4'b0000, rx_word(b[i]), 32'h0);
		end
		for (i = 0; i < 4; i++)
			add_entry(op_read, addr_data, 4'b0000, 32'h0, rx_word(b[i]));
		add_entry(op_read, addr_data, 4'b0000, 32'h0, 32'hffff_ffff);
		rand_byte(r);
		add_entry(op_expect_tx, addr_data, 4'b0001, {24'ha5a5a5, r}, rx_word(r));
		// Sticky error, LEDs must keep their value
		add_entry(op_no_ready, addr_unmapped, 4'b0000, 32'h0, led_word(32'hffff_ffea));
		add_entry(op_no_ready, addr_led, 4'b1111, 32'h1f, led_word(32'hffff_ffea));
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
		end
	endtask

	task automatic bus_access(input addr_t addr, input strb_t strb, input word_t wdata,
			output word_t rdata, output logic timed_out, output int latency);
		latency = 0;
		timed_out = 1'b0;
		rdata = '0;
		@(negedge clk);
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wstrb = strb;
		mem_wdata = wdata;
		@(negedge clk);
		while (!mem_ready && !timed_out) begin
			if (latency >= bus_watchdog) begin
				timed_out = 1'b1;
			end else begin
				latency++;
				@(negedge clk);
			end
		end
		if (!timed_out) begin
			rdata = mem_rdata;
			ready_cycle = cycle;
			// Valid drops in the cycle after ready
			@(negedge clk);
		end
		mem_valid = 1'b0;
		mem_wstrb = '0;
	endtask

	task automatic send_byte(input byte_t b);
		int i;
		@(negedge clk);
		rx = 1'b0;
		repeat (clks_per_bit) @(negedge clk);
		for (i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (clks_per_bit) @(negedge clk);
		end
		rx = 1'b1;
		repeat (clks_per_bit + 4) @(negedge clk);
	endtask

	// Samples tx in the middle of each bit
	task automatic watch_tx(input byte_t exp);
		byte_t got;
		int waited;
		int i;
		waited = 0;
		got = '0;
		@(negedge clk);
		while (tx && waited < bus_watchdog) begin
			@(negedge clk);
			waited++;
		end
		if (tx) begin
			errors++;
			$display("No start bit appeared on tx for the serial write");
		end else begin
			repeat (clks_per_bit / 2) @(negedge clk);
			check_value("tx start bit", word_t'(tx), 32'd0);
			for (i = 0; i < 8; i++) begin
				repeat (clks_per_bit) @(negedge clk);
				got[i] = tx;
			end
			repeat (clks_per_bit) @(negedge clk);
			check_value("tx stop bit", word_t'(tx), 32'd1);
			stop_cycle = cycle;
			check_value("tx data", rx_word(got), rx_word(exp));
		end
	endtask

	initial begin
		word_t rdata;
		logic timed_out;
		int latency;
		int k;
		clk = 1'b0;
		resetn = 1'b0;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		rx = 1'b1;
		errors = 0;
		rng = 32'd71143;
		build_table();
		cycle_limit = n_entries * 12 * clks_per_bit + 1000;
		repeat (2) @(negedge clk);
		resetn = 1'b1;
		check_value("tx", word_t'(tx), 32'd1);
		check_value("leds", word_t'(leds), 32'd0);
		check_value("bus_error", word_t'(bus_error), 32'd0);
		check_value("mem_ready", word_t'(mem_ready), 32'd0);
		for (k = 0; k < n_entries; k++) begin
			case (t_op[k])
				op_write, op_read: begin
					bus_access(t_addr[k], t_strb[k], t_data[k], rdata, timed_out, latency);
					if (timed_out) begin
						errors++;
						$display("Access to 0x%08h got no ready in time", t_addr[k]);
					end else if (t_op[k] == op_read) begin
						check_value("mem_rdata", rdata, t_exp[k]);
					end else begin
						check_value("leds", word_t'(leds), t_exp[k]);
					end
					if (t_addr[k] == addr_led)
						check_value("led ready latency", word_t'(latency), 32'd0);
				end
				op_send: send_byte(t_data[k][7:0]);
				op_expect_tx: begin
					fork
						bus_access(t_addr[k], t_strb[k], t_data[k], rdata, timed_out, latency);
						watch_tx(t_exp[k][7:0]);
					join
					if (timed_out) begin
						errors++;
						$display("Serial write got no ready in time");
					end else if (ready_cycle <= stop_cycle) begin
						errors++;
						$display("Serial write got its ready before the stop bit");
					end
				end
				op_no_ready: begin
					bus_access(t_addr[k], t_strb[k], t_data[k], rdata, timed_out, latency);
					if (!timed_out) begin
						errors++;
						$display("Access to 0x%08h got a ready after a bus error", t_addr[k]);
					end
					check_value("bus_error", word_t'(bus_error), 32'd1);
					check_value("leds", word_t'(leds), t_exp[k]);
				end
				default: begin
					errors++;
					$display("Unknown operation in stimulus entry %0d", k);
				end
			endcase
		end
		repeat (10) @(negedge clk);
		$display("Checks done: %0d errors over %0d entries", errors, n_entries);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/serial_io_top.sv
// Top level with register block, receiver, receive buffer and transmitter
`timescale 1ns/10ps
`default_nettype none

module serial_io_top import serial_pkg::*; (
	input wire logic clk,
	input wire logic resetn,
	input wire logic mem_valid,
	input wire addr_t mem_addr,
	input wire word_t mem_wdata,
	input wire strb_t mem_wstrb,
	output logic mem_ready,
	output word_t mem_rdata,
	input wire logic rx,
	output logic tx,
	output led_t leds,
	output logic bus_error
);

	logic regs_ready;
	word_t regs_rdata;
	logic uart_wr_valid;
	logic uart_rd_valid;
	byte_t uart_wr_data;
	logic byte_valid;
	byte_t byte_data;
	logic rd_ready;
	word_t rd_data;
	logic tx_ready;

	io_regs regs (
		.clk(clk),
		.resetn(resetn),
		.mem_valid(mem_valid),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.regs_ready(regs_ready),
		.regs_rdata(regs_rdata),
		.leds(leds),
		.bus_error(bus_error),
		.uart_wr_valid(uart_wr_valid),
		.uart_rd_valid(uart_rd_valid),
		.uart_wr_data(uart_wr_data)
	);

	uart_rx rx_unit (
		.clk(clk),
		.resetn(resetn),
		.rx(rx),
		.byte_valid(byte_valid),
		.byte_data(byte_data)
	);

	uart_rx_buffer rx_buf (
		.clk(clk),
		.resetn(resetn),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.rd_valid(uart_rd_valid),
		.rd_ready(rd_ready),
		.rd_data(rd_data)
	);

	uart_tx tx_unit (
		.clk(clk),
		.resetn(resetn),
		.wr_valid(uart_wr_valid),
		.wr_data(uart_wr_data),
		.tx_ready(tx_ready),
		.tx(tx)
	);

	// Only one responder per access
	assign mem_ready = regs_ready | tx_ready | rd_ready;
	assign mem_rdata = rd_ready ? rd_data : regs_rdata;

endmodule

`default_nettype wire

//--- logic/io_regs.sv
// Address decode, LED register, sticky bus error and serial strobes
`timescale 1ns/10ps
`default_nettype none

`include "serial_config.svh"

module io_regs import serial_pkg::*; (
	input wire logic clk,
	input wire logic resetn,
	input wire logic mem_valid,
	input wire addr_t mem_addr,
	input wire word_t mem_wdata,
	input wire strb_t mem_wstrb,
	output logic regs_ready,
	output word_t regs_rdata,
	output led_t leds,
	output logic bus_error,
	output logic uart_wr_valid,
	output logic uart_rd_valid,
	output byte_t uart_wr_data
);

	logic addr_led;
	logic addr_data;
	logic access;
	logic is_write;
	logic led_hit;

	assign addr_led = mem_addr == `SERIAL_ADDR_LED;
	assign addr_data = mem_addr == `SERIAL_ADDR_DATA;
	assign is_write = |mem_wstrb;

	// Nothing passes once the error is set
	assign access = mem_valid && !bus_error;
	assign led_hit = access && !regs_ready && addr_led;

	// Serial register is served by the UART blocks
	assign uart_wr_valid = access && addr_data && is_write;
	assign uart_rd_valid = access && addr_data && !is_write;
	assign uart_wr_data = mem_wdata[7:0];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			regs_ready <= 1'b0;
			bus_error <= 1'b0;
			leds <= '0;
		end else begin
			regs_ready <= 1'b0;
			if (led_hit) begin
				regs_ready <= 1'b1;
				if (mem_wstrb[0])
					leds <= mem_wdata[4:0];
			end else if (access && !regs_ready && !addr_data) begin
				// unmapped, stays set until reset
				bus_error <= 1'b1;
			end
		end
	end

	// Read returns the value before any write in the same access
	always_ff @(posedge clk) begin
		if (led_hit)
			regs_rdata <= word_t'(leds);
	end

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
// Serial transmitter with bit-period divider and frame shift register
`timescale 1ns/10ps
`default_nettype none

`include "serial_config.svh"

module uart_tx import serial_pkg::*; (
	input wire logic clk,
	input wire logic resetn,
	input wire logic wr_valid,
	input wire byte_t wr_data,
	output logic tx_ready,
	output logic tx
);

	localparam bit_cnt_t div_last = bit_cnt_t'(`SERIAL_CLKS_PER_BIT - 2);

	bit_cnt_t div_cnt;
	logic div_pre;
	logic div_pulse;
	tx_state_t state;
	logic [8:0] sreg;
	logic [3:0] remain;

	// Free running, one pulse per bit period
	assign div_pre = div_cnt == div_last;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			div_cnt <= '0;
			div_pulse <= 1'b0;
		end else begin
			div_cnt <= div_pulse ? '0 : div_cnt + 1'b1;
			div_pulse <= div_pre;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= tx_idle;
			sreg <= '1;
			remain <= '0;
			tx_ready <= 1'b0;
		end else begin
			// Last clock of the stop bit
			tx_ready <= state == tx_shift && remain == 4'd1 && div_pre;
			if (div_pulse) begin
				case (state)
					tx_idle: begin
						if (wr_valid && !tx_ready) begin
							sreg <= {wr_data, 1'b0};
							remain <= 4'd10;
							state <= tx_shift;
						end
					end
					tx_shift: begin
						sreg <= {1'b1, sreg[8:1]};
						remain <= remain - 1'b1;
						if (remain == 4'd1)
							state <= tx_idle;
					end
					default: state <= tx_idle;
				endcase
			end
		end
	end

	assign tx = sreg[0];

endmodule

`default_nettype wire

//--- uart/uart_rx_buffer.sv
// Four-byte receive buffer with byte packing and bus pop
`timescale 1ns/10ps
`default_nettype none

module uart_rx_buffer import serial_pkg::*; (
	input wire logic clk,
	input wire logic resetn,
	input wire logic byte_valid,
	input wire byte_t byte_data,
	input wire logic rd_valid,
	output logic rd_ready,
	output word_t rd_data
);

	word_t rbuf;
	logic [3:0] fill;
	logic pop;

	// An arriving byte wins over a read in the same cycle
	assign pop = rd_valid && !rd_ready && !byte_valid;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			fill <= '0;
			rd_ready <= 1'b0;
		end else begin
			rd_ready <= 1'b0;
			if (byte_valid) begin
				fill <= {fill[2:0], 1'b1};
			end else if (pop) begin
				fill <= fill >> 1;
				rd_ready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid) begin
			// Lowest free lane, nothing is written when full
			case (fill)
				4'b0000: rbuf[7:0] <= byte_data;
				4'b0001: rbuf[15:8] <= byte_data;
				4'b0011: rbuf[23:16] <= byte_data;
				4'b0111: rbuf[31:24] <= byte_data;
				default: rbuf <= rbuf;
			endcase
		end else if (pop) begin
			rbuf <= rbuf >> 8;
			if (fill[0])
				rd_data <= word_t'(rbuf[7:0]);
			else
				rd_data <= '1;
		end
	end

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
// Serial receiver with input synchronizer and bit-sampling FSM
`timescale 1ns/10ps
`default_nettype none

`include "serial_config.svh"

module uart_rx import serial_pkg::*; (
	input wire logic clk,
	input wire logic resetn,
	input wire logic rx,
	output logic byte_valid,
	output byte_t byte_data
);

	localparam bit_cnt_t half_bit = bit_cnt_t'(`SERIAL_CLKS_PER_BIT / 2 - 1);
	localparam bit_cnt_t full_bit = bit_cnt_t'(`SERIAL_CLKS_PER_BIT - 1);

	logic rx_meta;
	logic rx_sync;
	logic rx_last;
	rx_state_t state;
	bit_cnt_t cnt;
	logic [2:0] bit_idx;
	byte_t shift;

	// Line idles high, so the synchronizer resets to one
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= rx_idle;
			cnt <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			case (state)
				rx_idle: begin
					if (rx_last && !rx_sync) begin
						cnt <= half_bit;
						state <= rx_start;
					end
				end
				rx_start: begin
					// Middle of the start bit, a high line here was a glitch
					if (cnt == '0) begin
						if (!rx_sync) begin
							cnt <= full_bit;
							bit_idx <= '0;
							state <= rx_data;
						end else begin
							state <= rx_idle;
						end
					end
				end
				rx_data: begin
					if (cnt == '0) begin
						cnt <= full_bit;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end
				end
				rx_stop: begin
					// Frames with a low stop bit are discarded
					if (cnt == '0) begin
						byte_valid <= rx_sync;
						state <= rx_idle;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clk) begin
		if (state == rx_data && cnt == '0)
			shift <= {rx_sync, shift[7:1]};
	end

	assign byte_data = shift;

endmodule

`default_nettype wire

//--- common/serial_pkg.sv
// Package with bus and serial vector types and FSM state enums
`default_nettype none

package serial_pkg;

	// Bus fields
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0] strb_t;

	// Serial payload and board outputs
	typedef logic [7:0] byte_t;
	typedef logic [4:0] led_t;

	// Counts clocks inside one bit period
	typedef logic [7:0] bit_cnt_t;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	typedef enum logic {
		tx_idle,
		tx_shift
	} tx_state_t;

endpackage

`default_nettype wire

//--- common/serial_config.svh
// Serial bit timing and register address macros
`ifndef SERIAL_CONFIG_SVH
`define SERIAL_CONFIG_SVH

// Clocks per serial bit, 12 MHz at about 115200 baud
`define SERIAL_CLKS_PER_BIT 104

// Register map
`define SERIAL_ADDR_LED  32'h0200_0000
`define SERIAL_ADDR_DATA 32'h0200_0004

`endif
